// ==== verilog/fsctl_pkg.sv ====
package fsctl_pkg;

	// ---------------------------------------------------------------------------
	// widths
	// ---------------------------------------------------------------------------
	typedef logic [7:0]  reg_idx_t;
	typedef logic [31:0] reg_data_t;
	typedef logic [11:0] img_w_t;
	typedef logic [11:0] img_h_t;
	typedef logic [1:0]  buf_idx_t;
	typedef logic [1:0]  dst_bmp_t;

	localparam int N_STREAMS            = 2;
	localparam int GEOM_REGS_PER_STREAM = 5;
	localparam int N_GEOM_REGS          = N_STREAMS * GEOM_REGS_PER_STREAM;

	// per-stream fields sit every 4 bits
	localparam int STREAM_STRIDE  = 4;
	localparam int STREAM_INT_LSB = 4;
	// vertical half of a geometry word
	localparam int GEOM_V_LSB     = 16;

	// ---------------------------------------------------------------------------
	// register map
	// ---------------------------------------------------------------------------
	localparam reg_idx_t REG_CTRL      = 8'd0;
	localparam reg_idx_t REG_DST_BMP   = 8'd1;
	localparam reg_idx_t REG_INT_EN    = 8'd2;
	localparam reg_idx_t REG_INT_STATE = 8'd3;
	localparam reg_idx_t REG_BUF_IDX   = 8'd4;
	localparam reg_idx_t REG_GEOM_BASE = 8'd5;
	localparam reg_idx_t REG_VERSION   = 8'd255;

	typedef struct packed {
		logic      en;
		reg_idx_t  addr;
		reg_data_t data;
	} host_wr_t;

	// active config of one stream
	typedef struct packed {
		logic     soft_resetn;
		dst_bmp_t dst_bmp;
		img_w_t   width;
		img_h_t   height;
		img_w_t   win_left;
		img_h_t   win_top;
		img_w_t   win_width;
		img_h_t   win_height;
		img_w_t   win_righte;
		img_h_t   win_bottome;
		img_w_t   dst_left;
		img_h_t   dst_top;
		img_w_t   dst_width;
		img_h_t   dst_height;
		img_w_t   dst_righte;
		img_h_t   dst_bottome;
	} stream_cfg_t;

endpackage

// ==== verilog/host_reg_port.sv ====
`timescale 1ns/1ps

module host_reg_port #(
	parameter fsctl_pkg::reg_data_t CORE_VERSION = 32'hFF00FF00
) (
	input  logic                                                  o_clk,
	input  logic                                                  o_resetn,
	input  logic                                                  i_wr_en,
	input  fsctl_pkg::reg_idx_t                                   i_wr_addr,
	input  fsctl_pkg::reg_data_t                                  i_wr_data,
	input  logic                                                  i_rd_en,
	input  fsctl_pkg::reg_idx_t                                   i_rd_addr,
	input  fsctl_pkg::reg_data_t                                  i_ctrl_word,
	input  fsctl_pkg::reg_data_t                                  i_bmp_word,
	input  fsctl_pkg::reg_data_t [fsctl_pkg::N_GEOM_REGS-1:0]     i_geom_words,
	input  fsctl_pkg::reg_data_t                                  i_int_en_word,
	input  fsctl_pkg::reg_data_t                                  i_int_state_word,
	input  fsctl_pkg::buf_idx_t [fsctl_pkg::N_STREAMS-1:0]        i_rd_buf_idx,
	output fsctl_pkg::host_wr_t                                   o_wr,
	output fsctl_pkg::reg_data_t                                  o_rd_data
);
	import fsctl_pkg::*;

	reg_data_t buf_idx_word;
	reg_data_t rd_mux;

	// ---------------------------------------------------------------------------
	// write path
	// ---------------------------------------------------------------------------
	// one register stage ahead of the target decoders
	always_ff @(posedge o_clk) begin
		o_wr.addr <= i_wr_addr;
		o_wr.data <= i_wr_data;
		if (!o_resetn)
			o_wr.en <= 1'b0;
		else
			o_wr.en <= i_wr_en;
	end

	// ---------------------------------------------------------------------------
	// read path
	// ---------------------------------------------------------------------------
	always_comb begin
		buf_idx_word = '0;
		for (int s = 0; s < N_STREAMS; s++) begin
			buf_idx_word[STREAM_INT_LSB + STREAM_STRIDE * s +: $bits(buf_idx_t)] =
				i_rd_buf_idx[s];
		end
	end

	always_comb begin
		rd_mux = '0;
		case (i_rd_addr)
			REG_CTRL:      rd_mux = i_ctrl_word;
			REG_DST_BMP:   rd_mux = i_bmp_word;
			REG_INT_EN:    rd_mux = i_int_en_word;
			REG_INT_STATE: rd_mux = i_int_state_word;
			REG_BUF_IDX:   rd_mux = buf_idx_word;
			REG_VERSION:   rd_mux = CORE_VERSION;
			default: begin
				// geometry block or zero when unmapped
				for (int g = 0; g < N_GEOM_REGS; g++) begin
					if (i_rd_addr == reg_idx_t'(int'(REG_GEOM_BASE) + g))
						rd_mux = i_geom_words[g];
				end
			end
		endcase
	end

	// data holds until the next read strobe
	always_ff @(posedge o_clk) begin
		if (!o_resetn)
			o_rd_data <= '0;
		else if (i_rd_en)
			o_rd_data <= rd_mux;
	end

endmodule

// ==== verilog/fsync_edge.sv ====
`timescale 1ns/1ps

module fsync_edge (
	input  logic o_clk,
	input  logic o_resetn,
	input  logic i_fsync,
	input  logic i_cfging,
	output logic o_commit,
	output logic o_fsync
);
	logic fsync_d1;
	logic fsync_d2;
	logic fsync_rise;

	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			fsync_d1 <= 1'b0;
			fsync_d2 <= 1'b0;
		end else begin
			fsync_d1 <= i_fsync;
			fsync_d2 <= fsync_d1;
		end
	end

	assign fsync_rise = fsync_d1 & ~fsync_d2;

	// no commit while the host is mid-update
	assign o_commit = fsync_rise & ~i_cfging;

	// lines up with the new config on the output
	always_ff @(posedge o_clk) begin
		if (!o_resetn)
			o_fsync <= 1'b0;
		else
			o_fsync <= fsync_rise;
	end

endmodule

// ==== verilog/disp_cfg_bank.sv ====
`timescale 1ns/1ps

module disp_cfg_bank (
	input  logic                                                  o_clk,
	input  logic                                                  o_resetn,
	input  fsctl_pkg::host_wr_t                                   i_wr,
	input  logic                                                  i_commit,
	output fsctl_pkg::reg_data_t                                  o_ctrl_word,
	output fsctl_pkg::reg_data_t                                  o_bmp_word,
	output fsctl_pkg::reg_data_t [fsctl_pkg::N_GEOM_REGS-1:0]     o_geom_words,
	output logic                                                  o_cfging,
	output logic                                                  o_soft_resetn,
	output fsctl_pkg::stream_cfg_t [fsctl_pkg::N_STREAMS-1:0]     o_stream_cfg
);
	import fsctl_pkg::*;

	logic                   wr_ctrl;
	logic                   wr_bmp;
	logic [N_GEOM_REGS-1:0] wr_geom;

	dst_bmp_t bmp_stg [N_STREAMS];
	img_w_t   geom_h  [N_GEOM_REGS];
	img_h_t   geom_v  [N_GEOM_REGS];

	assign wr_ctrl = i_wr.en && (i_wr.addr == REG_CTRL);
	assign wr_bmp  = i_wr.en && (i_wr.addr == REG_DST_BMP);

	// ---------------------------------------------------------------------------
	// control register takes effect right away
	// ---------------------------------------------------------------------------
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_soft_resetn <= 1'b0;
			o_cfging      <= 1'b0;
		end else if (wr_ctrl) begin
			o_soft_resetn <= i_wr.data[0];
			o_cfging      <= i_wr.data[1];
		end
	end

	assign o_ctrl_word = {{($bits(reg_data_t) - 2){1'b0}}, o_cfging, o_soft_resetn};

	// ---------------------------------------------------------------------------
	// staged geometry
	// ---------------------------------------------------------------------------
	for (genvar g = 0; g < N_GEOM_REGS; g++) begin : g_geom
		assign wr_geom[g] = i_wr.en && (i_wr.addr == reg_idx_t'(int'(REG_GEOM_BASE) + g));

		always_ff @(posedge o_clk) begin
			if (!o_resetn) begin
				geom_h[g] <= '0;
				geom_v[g] <= '0;
			end else if (wr_geom[g]) begin
				geom_h[g] <= i_wr.data[$bits(img_w_t)-1:0];
				geom_v[g] <= i_wr.data[GEOM_V_LSB +: $bits(img_h_t)];
			end
		end

		assign o_geom_words[g] = {
			{($bits(reg_data_t) - GEOM_V_LSB - $bits(img_h_t)){1'b0}},
			geom_v[g],
			{(GEOM_V_LSB - $bits(img_w_t)){1'b0}},
			geom_h[g]
		};
	end

	assign o_bmp_word[$bits(reg_data_t)-1:STREAM_STRIDE*N_STREAMS] = '0;

	// ---------------------------------------------------------------------------
	// per-stream staged bitmap and active config
	// ---------------------------------------------------------------------------
	for (genvar s = 0; s < N_STREAMS; s++) begin : g_stream
		localparam int B = s * GEOM_REGS_PER_STREAM;
		stream_cfg_t cfg_next;

		always_ff @(posedge o_clk) begin
			if (!o_resetn)
				bmp_stg[s] <= '0;
			else if (wr_bmp)
				bmp_stg[s] <= i_wr.data[STREAM_STRIDE * s +: $bits(dst_bmp_t)];
		end

		assign o_bmp_word[STREAM_STRIDE * s +: STREAM_STRIDE] =
			{{(STREAM_STRIDE - $bits(dst_bmp_t)){1'b0}}, bmp_stg[s]};

		// edge sums wrap at field width
		always_comb begin
			cfg_next.soft_resetn = (bmp_stg[s] != '0);
			cfg_next.dst_bmp     = bmp_stg[s];
			cfg_next.width       = geom_h[B];
			cfg_next.height      = geom_v[B];
			cfg_next.win_left    = geom_h[B + 1];
			cfg_next.win_top     = geom_v[B + 1];
			cfg_next.win_width   = geom_h[B + 2];
			cfg_next.win_height  = geom_v[B + 2];
			cfg_next.win_righte  = geom_h[B + 1] + geom_h[B + 2];
			cfg_next.win_bottome = geom_v[B + 1] + geom_v[B + 2];
			cfg_next.dst_left    = geom_h[B + 3];
			cfg_next.dst_top     = geom_v[B + 3];
			cfg_next.dst_width   = geom_h[B + 4];
			cfg_next.dst_height  = geom_v[B + 4];
			cfg_next.dst_righte  = geom_h[B + 3] + geom_h[B + 4];
			cfg_next.dst_bottome = geom_v[B + 3] + geom_v[B + 4];
		end

		always_ff @(posedge o_clk) begin
			if (!o_resetn)
				o_stream_cfg[s] <= '0;
			else if (i_commit)
				o_stream_cfg[s] <= cfg_next;
		end
	end

endmodule

// ==== verilog/stream_irq_ctrl.sv ====
`timescale 1ns/1ps

module stream_irq_ctrl (
	input  logic                                o_clk,
	input  logic                                o_resetn,
	input  fsctl_pkg::host_wr_t                 i_wr,
	input  logic [fsctl_pkg::N_STREAMS-1:0]     i_wr_done,
	output fsctl_pkg::reg_data_t                o_int_en_word,
	output fsctl_pkg::reg_data_t                o_int_state_word,
	output logic [fsctl_pkg::N_STREAMS-1:0]     o_rd_en,
	output logic                                o_intr
);
	import fsctl_pkg::*;

	logic                 wr_int_en;
	logic                 wr_int_state;
	logic [N_STREAMS-1:0] wr_bits;
	logic [N_STREAMS-1:0] clr;
	logic [N_STREAMS-1:0] done_rise;
	logic [N_STREAMS-1:0] wr_done_d1;
	logic [N_STREAMS-1:0] int_en;
	logic [N_STREAMS-1:0] int_state;

	assign wr_int_en    = i_wr.en && (i_wr.addr == REG_INT_EN);
	assign wr_int_state = i_wr.en && (i_wr.addr == REG_INT_STATE);

	// per-stream bit of the written word
	always_comb begin
		for (int s = 0; s < N_STREAMS; s++) begin
			wr_bits[s] = i_wr.data[STREAM_INT_LSB + STREAM_STRIDE * s];
		end
	end

	// write one to clear
	assign clr       = wr_int_state ? wr_bits : '0;
	assign done_rise = i_wr_done & ~wr_done_d1;

	// ---------------------------------------------------------------------------
	// enables, sticky state, read-enable pulses
	// ---------------------------------------------------------------------------
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			wr_done_d1 <= '0;
			int_en     <= '0;
			int_state  <= '0;
			o_rd_en    <= '0;
		end else begin
			wr_done_d1 <= i_wr_done;
			o_rd_en    <= clr;
			if (wr_int_en)
				int_en <= wr_bits;
			// set wins over a clear on the same edge
			int_state <= done_rise | (int_state & ~clr);
		end
	end

	assign o_intr = |(int_en & int_state);

	always_comb begin
		o_int_en_word    = '0;
		o_int_state_word = '0;
		for (int s = 0; s < N_STREAMS; s++) begin
			o_int_en_word[STREAM_INT_LSB + STREAM_STRIDE * s]    = int_en[s];
			o_int_state_word[STREAM_INT_LSB + STREAM_STRIDE * s] = int_state[s];
		end
	end

endmodule

// ==== verilog/fsctl_top.sv ====
`timescale 1ns/1ps

module fsctl_top #(
	parameter fsctl_pkg::reg_data_t CORE_VERSION = 32'hFF00FF00
) (
	input  logic                                                o_clk,
	input  logic                                                o_resetn,
	input  logic                                                i_wr_en,
	input  fsctl_pkg::reg_idx_t                                 i_wr_addr,
	input  fsctl_pkg::reg_data_t                                i_wr_data,
	input  logic                                                i_rd_en,
	input  fsctl_pkg::reg_idx_t                                 i_rd_addr,
	input  logic                                                i_fsync,
	input  logic [fsctl_pkg::N_STREAMS-1:0]                     i_wr_done,
	input  fsctl_pkg::buf_idx_t [fsctl_pkg::N_STREAMS-1:0]      i_rd_buf_idx,
	output fsctl_pkg::reg_data_t                                o_rd_data,
	output logic                                                o_fsync,
	output logic                                                o_soft_resetn,
	output fsctl_pkg::stream_cfg_t [fsctl_pkg::N_STREAMS-1:0]   o_stream_cfg,
	output logic [fsctl_pkg::N_STREAMS-1:0]                     o_rd_en,
	output logic                                                o_intr
);
	import fsctl_pkg::*;

	host_wr_t                      wr;
	reg_data_t                     ctrl_word;
	reg_data_t                     bmp_word;
	reg_data_t [N_GEOM_REGS-1:0]   geom_words;
	reg_data_t                     int_en_word;
	reg_data_t                     int_state_word;
	logic                          cfging;
	logic                          commit;

	host_reg_port #(
		.CORE_VERSION(CORE_VERSION)
	) u_host_reg_port (
		.o_clk            (o_clk),
		.o_resetn         (o_resetn),
		.i_wr_en          (i_wr_en),
		.i_wr_addr        (i_wr_addr),
		.i_wr_data        (i_wr_data),
		.i_rd_en          (i_rd_en),
		.i_rd_addr        (i_rd_addr),
		.i_ctrl_word      (ctrl_word),
		.i_bmp_word       (bmp_word),
		.i_geom_words     (geom_words),
		.i_int_en_word    (int_en_word),
		.i_int_state_word (int_state_word),
		.i_rd_buf_idx     (i_rd_buf_idx),
		.o_wr             (wr),
		.o_rd_data        (o_rd_data)
	);

	fsync_edge u_fsync_edge (
		.o_clk    (o_clk),
		.o_resetn (o_resetn),
		.i_fsync  (i_fsync),
		.i_cfging (cfging),
		.o_commit (commit),
		.o_fsync  (o_fsync)
	);

	disp_cfg_bank u_disp_cfg_bank (
		.o_clk         (o_clk),
		.o_resetn      (o_resetn),
		.i_wr          (wr),
		.i_commit      (commit),
		.o_ctrl_word   (ctrl_word),
		.o_bmp_word    (bmp_word),
		.o_geom_words  (geom_words),
		.o_cfging      (cfging),
		.o_soft_resetn (o_soft_resetn),
		.o_stream_cfg  (o_stream_cfg)
	);

	stream_irq_ctrl u_stream_irq_ctrl (
		.o_clk            (o_clk),
		.o_resetn         (o_resetn),
		.i_wr             (wr),
		.i_wr_done        (i_wr_done),
		.o_int_en_word    (int_en_word),
		.o_int_state_word (int_state_word),
		.o_rd_en          (o_rd_en),
		.o_intr           (o_intr)
	);

endmodule

// ==== verification/tb_fsctl_assert.sv ====
`timescale 1ns/1ps

module tb_fsctl_assert (
	input logic                              o_clk,
	input logic                              o_resetn,
	input logic [fsctl_pkg::N_STREAMS-1:0]   i_rd_en,
	input logic                              i_intr,
	input fsctl_pkg::reg_data_t              i_int_en_word,
	input logic [fsctl_pkg::N_STREAMS-1:0]   i_wr_done,
	input logic                              i_fsync_raw,
	input logic                              i_cfging,
	input logic                              i_commit,
	input logic                              i_fsync
);
	import fsctl_pkg::*;

	// read-enable is a single-cycle pulse
	rd_en_single: assert property (@(posedge o_clk) disable iff (!o_resetn)
		(i_rd_en & $past(i_rd_en)) == '0)
		else $error("o_rd_en stayed high for more than one cycle");

	// a write-done edge on an enabled stream raises o_intr one edge later
	for (genvar s = 0; s < N_STREAMS; s++) begin : g_intr
		intr_on_done: assert property (@(posedge o_clk) disable iff (!o_resetn)
			$rose(i_wr_done[s]) |=>
				(i_intr || !i_int_en_word[STREAM_INT_LSB + STREAM_STRIDE * s]))
			else $error("write-done on an enabled stream did not raise o_intr");
	end

	// raw fsync edge gives a gated commit, then o_fsync
	commit_fsync: assert property (@(posedge o_clk) disable iff (!o_resetn)
		$rose(i_fsync_raw) |=> (i_commit == !i_cfging) ##1 i_fsync)
		else $error("commit or o_fsync did not follow the fsync rising edge");

endmodule

bind stream_irq_ctrl tb_fsctl_assert u_irq_assert (
	.o_clk            (o_clk),
	.o_resetn         (o_resetn),
	.i_rd_en          (o_rd_en),
	.i_intr           (o_intr),
	.i_int_en_word    (o_int_en_word),
	.i_wr_done        (i_wr_done),
	.i_fsync_raw      (1'b0),
	.i_cfging         (1'b0),
	.i_commit         (1'b0),
	.i_fsync          (1'b0)
);

bind fsync_edge tb_fsctl_assert u_fsync_assert (
	.o_clk            (o_clk),
	.o_resetn         (o_resetn),
	.i_rd_en          ('0),
	.i_intr           (1'b0),
	.i_int_en_word    ('0),
	.i_wr_done        ('0),
	.i_fsync_raw      (i_fsync),
	.i_cfging         (i_cfging),
	.i_commit         (o_commit),
	.i_fsync          (o_fsync)
);

// ==== verification/tb_fsctl.sv ====
`timescale 1ns/1ps

module tb_fsctl;
	import fsctl_pkg::*;

	localparam int CLK_PERIOD = 20;

	logic                            o_clk;
	logic                            o_resetn;
	logic                            i_wr_en;
	reg_idx_t                        i_wr_addr;
	reg_data_t                       i_wr_data;
	logic                            i_rd_en;
	reg_idx_t                        i_rd_addr;
	logic                            i_fsync;
	logic [N_STREAMS-1:0]            i_wr_done;
	buf_idx_t [N_STREAMS-1:0]        i_rd_buf_idx;
	reg_data_t                       o_rd_data;
	logic                            o_fsync;
	logic                            o_soft_resetn;
	stream_cfg_t [N_STREAMS-1:0]     o_stream_cfg;
	logic [N_STREAMS-1:0]            o_rd_en;
	logic                            o_intr;

	// operation list from the input file
	string     op_code_q [$];
	string     op_test_q [$];
	reg_data_t op_a_q [$];
	reg_data_t op_b_q [$];

	// reference model of staged and active config
	img_w_t      geom_h [N_STREAMS][GEOM_REGS_PER_STREAM];
	img_h_t      geom_v [N_STREAMS][GEOM_REGS_PER_STREAM];
	dst_bmp_t    bmp_shadow [N_STREAMS];
	stream_cfg_t exp_active [N_STREAMS];

	int          rd_en_pulses [N_STREAMS];
	int          checks;
	int          errors;
	logic [31:0] lfsr_state;

	fsctl_top #(
		.CORE_VERSION(32'hFF00FF00)
	) u_fsctl_top (
		.o_clk         (o_clk),
		.o_resetn      (o_resetn),
		.i_wr_en       (i_wr_en),
		.i_wr_addr     (i_wr_addr),
		.i_wr_data     (i_wr_data),
		.i_rd_en       (i_rd_en),
		.i_rd_addr     (i_rd_addr),
		.i_fsync       (i_fsync),
		.i_wr_done     (i_wr_done),
		.i_rd_buf_idx  (i_rd_buf_idx),
		.o_rd_data     (o_rd_data),
		.o_fsync       (o_fsync),
		.o_soft_resetn (o_soft_resetn),
		.o_stream_cfg  (o_stream_cfg),
		.o_rd_en       (o_rd_en),
		.o_intr        (o_intr)
	);

	initial begin
		o_clk = 1'b0;
		forever #(CLK_PERIOD / 2) o_clk = ~o_clk;
	end

	// count cycles with o_rd_en high per stream
	always @(posedge o_clk) begin
		for (int s = 0; s < N_STREAMS; s++) begin
			if (o_resetn && o_rd_en[s])
				rd_en_pulses[s]++;
		end
	end

	// ---------------------------------------------------------------------------
	// helpers
	// ---------------------------------------------------------------------------
	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic stream_cfg_t staged_cfg(input int s);
		stream_cfg_t c;
		c.soft_resetn = (bmp_shadow[s] != 2'b00);
		c.dst_bmp     = bmp_shadow[s];
		c.width       = geom_h[s][0];
		c.height      = geom_v[s][0];
		c.win_left    = geom_h[s][1];
		c.win_top     = geom_v[s][1];
		c.win_width   = geom_h[s][2];
		c.win_height  = geom_v[s][2];
		c.win_righte  = geom_h[s][1] + geom_h[s][2];
		c.win_bottome = geom_v[s][1] + geom_v[s][2];
		c.dst_left    = geom_h[s][3];
		c.dst_top     = geom_v[s][3];
		c.dst_width   = geom_h[s][4];
		c.dst_height  = geom_v[s][4];
		c.dst_righte  = geom_h[s][3] + geom_h[s][4];
		c.dst_bottome = geom_v[s][3] + geom_v[s][4];
		return c;
	endfunction

	task automatic check_value(input string test, input reg_data_t exp, input reg_data_t act);
		checks++;
		assert (act === exp) else begin
			$display("** Error: [%s] expected %h, actual %h", test, exp, act);
			errors++;
		end
	endtask

	// mirror staged registers from the register map
	task automatic track_write(input reg_idx_t addr, input reg_data_t data);
		int idx;
		if (addr == REG_DST_BMP) begin
			for (int s = 0; s < N_STREAMS; s++)
				bmp_shadow[s] = data[STREAM_STRIDE * s +: 2];
		end
		idx = int'(addr) - int'(REG_GEOM_BASE);
		if (idx >= 0 && idx < N_GEOM_REGS) begin
			geom_h[idx / GEOM_REGS_PER_STREAM][idx % GEOM_REGS_PER_STREAM] = data[11:0];
			geom_v[idx / GEOM_REGS_PER_STREAM][idx % GEOM_REGS_PER_STREAM] =
				data[GEOM_V_LSB +: 12];
		end
	endtask

	// returns once the target register has taken the value
	task automatic host_write(input reg_idx_t addr, input reg_data_t data);
		@(posedge o_clk);
		#2;
		i_wr_en   = 1'b1;
		i_wr_addr = addr;
		i_wr_data = data;
		@(posedge o_clk);
		#2;
		i_wr_en = 1'b0;
		@(posedge o_clk);
		#2;
		track_write(addr, data);
	endtask

	task automatic host_read(input string test, input reg_idx_t addr, input reg_data_t exp);
		@(posedge o_clk);
		#2;
		i_rd_en   = 1'b1;
		i_rd_addr = addr;
		@(posedge o_clk);
		#2;
		i_rd_en = 1'b0;
		check_value(test, exp, o_rd_data);
	endtask

	task automatic fsync_pulse(input string test);
		int waited;
		@(posedge o_clk);
		#2;
		i_fsync = 1'b1;
		waited  = 0;
		@(posedge o_clk);
		#2;
		while (!o_fsync && waited < 8) begin
			@(posedge o_clk);
			#2;
			waited++;
		end
		checks++;
		assert (o_fsync) else begin
			$display("[%s] o_fsync never pulsed after the fsync rising edge", test);
			errors++;
		end
		@(posedge o_clk);
		#2;
		check_value(test, 32'h0, 32'(o_fsync));
		i_fsync = 1'b0;
		repeat (3) @(posedge o_clk);
	endtask

	task automatic write_done_pulse(input int s);
		@(posedge o_clk);
		#2;
		i_wr_done[s] = 1'b1;
		repeat (2) @(posedge o_clk);
		#2;
		i_wr_done[s] = 1'b0;
		repeat (2) @(posedge o_clk);
	endtask

	task automatic random_geometry(input int s);
		img_w_t    h;
		img_h_t    v;
		reg_data_t data;
		for (int r = 0; r < GEOM_REGS_PER_STREAM; r++) begin
			h    = img_w_t'(take_bits(12));
			v    = img_h_t'(take_bits(12));
			data = {4'h0, v, 4'h0, h};
			host_write(reg_idx_t'(int'(REG_GEOM_BASE) + s * GEOM_REGS_PER_STREAM + r), data);
		end
	endtask

	// with applied set the staged values should now be active
	task automatic check_cfg(input string test, input int s, input logic applied);
		@(posedge o_clk);
		#2;
		if (applied)
			exp_active[s] = staged_cfg(s);
		checks++;
		assert (o_stream_cfg[s] === exp_active[s]) else begin
			$display("** Error: [%s] stream %0d config expected %h, actual %h",
				test, s, exp_active[s], o_stream_cfg[s]);
			errors++;
		end
	endtask

	task automatic check_signal(input string test, input int sel, input reg_data_t exp);
		reg_data_t act;
		@(posedge o_clk);
		#2;
		case (sel)
			0:       act = 32'(o_intr);
			1:       act = 32'(o_soft_resetn);
			2:       act = 32'(o_fsync);
			3:       act = rd_en_pulses[0];
			default: act = rd_en_pulses[1];
		endcase
		check_value(test, exp, act);
	endtask

	task automatic load_ops();
		int        fd;
		int        n;
		string     line;
		string     code;
		string     test;
		reg_data_t a;
		reg_data_t b;
		fd = $fopen("verification/fsctl_input.txt", "r");
		if (fd == 0) begin
			$display("could not open verification/fsctl_input.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%s %s %h %h", code, test, a, b);
					if (n == 4) begin
						op_code_q.push_back(code);
						op_test_q.push_back(test);
						op_a_q.push_back(a);
						op_b_q.push_back(b);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_op(input int i);
		string     test;
		reg_data_t a;
		reg_data_t b;
		test = op_test_q[i];
		a    = op_a_q[i];
		b    = op_b_q[i];
		case (op_code_q[i])
			"wr": host_write(reg_idx_t'(a), b);
			"rd": host_read(test, reg_idx_t'(a), b);
			"fs": fsync_pulse(test);
			"wd": write_done_pulse(int'(a));
			"rg": random_geometry(int'(a));
			"cf": check_cfg(test, int'(a), b[0]);
			"ck": check_signal(test, int'(a), b);
			"bi": begin
				@(posedge o_clk);
				#2;
				i_rd_buf_idx = a[$bits(i_rd_buf_idx)-1:0];
			end
			default: begin
				$display("[%s] unknown operation %s in the input file", test, op_code_q[i]);
				errors++;
			end
		endcase
	endtask

	// ---------------------------------------------------------------------------
	// main sequence and watchdog
	// ---------------------------------------------------------------------------
	initial begin
		o_resetn     = 1'b0;
		i_wr_en      = 1'b0;
		i_wr_addr    = '0;
		i_wr_data    = '0;
		i_rd_en      = 1'b0;
		i_rd_addr    = '0;
		i_fsync      = 1'b0;
		i_wr_done    = '0;
		i_rd_buf_idx = '0;
		lfsr_state   = 32'he508;
		checks       = 0;
		errors       = 0;
		for (int s = 0; s < N_STREAMS; s++) begin
			bmp_shadow[s]   = '0;
			exp_active[s]   = '0;
			rd_en_pulses[s] = 0;
			for (int r = 0; r < GEOM_REGS_PER_STREAM; r++) begin
				geom_h[s][r] = '0;
				geom_v[s][r] = '0;
			end
		end
		load_ops();
		if (op_code_q.size() == 0) begin
			$display("no operations were loaded, nothing to run");
			$display("sim failed");
			$finish;
		end else begin
			repeat (8) @(posedge o_clk);
			#2;
			o_resetn = 1'b1;
			for (int i = 0; i < op_code_q.size(); i++)
				run_op(i);
			repeat (4) @(posedge o_clk);
			$display("checks run: %0d, errors: %0d", checks, errors);
			if (errors == 0)
				$display("sim passed");
			else
				$display("sim failed");
			$finish;
		end
	end

	// 40 cycles per operation plus reset margin
	initial begin
		#1;
		#((op_code_q.size() * 40 + 200) * CLK_PERIOD);
		$display("timeout, the operation list did not finish in time");
		$display("sim failed");
		$finish;
	end

endmodule

// ==== verification/fsctl_input.txt ====
# op test a b, a and b in hex; wr addr data, rd addr expected, fs fsync pulse, wd stream a
# rg random geometry stream a, bi buf idx a, cf stream a b=1 applied, ck sel a expected b
ck reset 0 0
ck reset 1 0
ck reset 2 0
ck reset 3 0
cf reset 0 0
cf reset 1 0
rd reset 0 0
rd reset 1 0
rd reset 3 0
rd reset 5 0
rd reset e 0
rd version ff ff00ff00
wr readback 0 ffffffff
rd readback 0 3
ck readback 1 1
wr readback 1 ffffffff
rd readback 1 33
wr readback 2 ffffffff
rd readback 2 110
wr readback 6 ffffffff
rd readback 6 0fff0fff
bi readback e 0
rd readback 4 320
rd readback 80 0
wr staged 0 1
wr staged 1 21
rg staged 0 0
cf staged 0 0
cf staged 1 0
fs staged 0 0
cf staged 0 1
cf staged 1 1
wr suppress 0 3
rg suppress 1 0
wr suppress 1 0
fs suppress 0 0
cf suppress 0 0
cf suppress 1 0
wr suppress 0 1
fs suppress 0 0
cf suppress 0 1
cf suppress 1 1
wr irq 2 10
wd irq 0 0
rd irq 3 10
ck irq 0 1
wr irq 3 10
rd irq 3 0
ck irq 0 0
ck irq 3 1
ck irq 4 0
wd irq 1 0
rd irq 3 100
ck irq 0 0

// ==== tb.f ====
verilog/fsctl_pkg.sv
verilog/host_reg_port.sv
verilog/fsync_edge.sv
verilog/disp_cfg_bank.sv
verilog/stream_irq_ctrl.sv
verilog/fsctl_top.sv
verification/tb_fsctl_assert.sv
verification/tb_fsctl.sv

// ==== Makefile ====
SRCS := $(wildcard verilog/*.sv verification/*.sv)

.PHONY: run clean

obj_dir/Vtb_fsctl: tb.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_fsctl -f tb.f -o Vtb_fsctl

run: obj_dir/Vtb_fsctl
	@out="$$(./obj_dir/Vtb_fsctl)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
